// File: hw/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////
    typedef logic [31:0] wordT;
    typedef logic [31:0] addrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    localparam int NumRegs     = 32;
    localparam int MemWords    = 64;
    localparam int MemAddrBits = $clog2(MemWords * 4);    // byte index into data memory
    localparam addrT ResetPc   = 32'h0000_0000;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////
    localparam opcodeT OpRType  = 6'b000000;
    localparam opcodeT OpRegImm = 6'b000001;    // bgez / bltz, rt picks which
    localparam opcodeT OpJ      = 6'b000010;
    localparam opcodeT OpJal    = 6'b000011;
    localparam opcodeT OpBeq    = 6'b000100;
    localparam opcodeT OpBne    = 6'b000101;
    localparam opcodeT OpBlez   = 6'b000110;
    localparam opcodeT OpBgtz   = 6'b000111;
    localparam opcodeT OpAddi   = 6'b001000;
    localparam opcodeT OpJr     = 6'b001001;
    localparam opcodeT OpSlti   = 6'b001010;
    localparam opcodeT OpAndi   = 6'b001100;
    localparam opcodeT OpOri    = 6'b001101;
    localparam opcodeT OpXori   = 6'b001110;
    localparam opcodeT OpLb     = 6'b100000;
    localparam opcodeT OpLh     = 6'b100001;
    localparam opcodeT OpLw     = 6'b100011;
    localparam opcodeT OpSb     = 6'b101000;
    localparam opcodeT OpSh     = 6'b101001;
    localparam opcodeT OpSw     = 6'b101011;

    localparam functT FnSll = 6'b000000;
    localparam functT FnSrl = 6'b000010;
    localparam functT FnMul = 6'b011100;
    localparam functT FnAdd = 6'b100000;
    localparam functT FnSub = 6'b100010;
    localparam functT FnAnd = 6'b100100;
    localparam functT FnOr  = 6'b100101;
    localparam functT FnXor = 6'b100110;
    localparam functT FnNor = 6'b100111;
    localparam functT FnSlt = 6'b101010;

    localparam regIdxT RtBltz = 5'd0;
    localparam regIdxT RtBgez = 5'd1;
    localparam regIdxT RaIdx  = 5'd31;    // link register

    localparam logic [1:0] RegDstRt = 2'd0;
    localparam logic [1:0] RegDstRd = 2'd1;
    localparam logic [1:0] RegDstRa = 2'd2;

    ////////////////////////////////////////////////////////////
    // control and retire
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        MemNone = 2'b00,
        MemWord = 2'b01,
        MemHalf = 2'b10,
        MemByte = 2'b11
    } memSizeT;

    typedef enum logic [4:0] {
        AluAdd, AluSub, AluMul, AluSll, AluSrl, AluAnd, AluOr, AluXor,
        AluNor, AluSlt, AluEq, AluNe, AluGez, AluLtz, AluGtz, AluLez
    } aluOpT;

    typedef struct packed {
        logic       regWrite;
        logic       aluSrcImm;
        logic       immZeroExt;
        logic [1:0] regDst;
        memSizeT    memRead;
        memSizeT    memWrite;
        logic       memToReg;
        logic       shiftImm;
        logic       branch;
        logic       jump;
        logic       jumpReg;
        logic       link;
        aluOpT      aluOp;
    } ctrlT;

    typedef struct packed {
        logic   valid;
        logic   regWe;
        regIdxT rd;
        wordT   data;
        addrT   pc;
        addrT   nextPc;
    } retireT;

endpackage

// File: hw/mainDecoder.sv
module mainDecoder (
    input  mipsPkg::wordT instr,
    output mipsPkg::ctrlT ctrl
);
    import mipsPkg::*;

    opcodeT opcode;
    functT  funct;
    regIdxT rt;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rt     = instr[20:16];    // second opcode field for bgez/bltz

    ////////////////////////////////////////////////////////////
    // control words per instruction class
    ////////////////////////////////////////////////////////////
    function automatic ctrlT loadCtrl(memSizeT size);
        ctrlT c;
        c           = '0;
        c.regWrite  = 1'b1;
        c.aluSrcImm = 1'b1;
        c.regDst    = RegDstRt;
        c.memRead   = size;
        c.memToReg  = 1'b1;
        c.aluOp     = AluAdd;    // base + offset
        return c;
    endfunction

    function automatic ctrlT storeCtrl(memSizeT size);
        ctrlT c;
        c           = '0;
        c.aluSrcImm = 1'b1;
        c.memWrite  = size;
        c.aluOp     = AluAdd;
        return c;
    endfunction

    function automatic ctrlT immCtrl(aluOpT op, logic zeroExt);
        ctrlT c;
        c            = '0;
        c.regWrite   = 1'b1;
        c.aluSrcImm  = 1'b1;
        c.immZeroExt = zeroExt;
        c.regDst     = RegDstRt;
        c.aluOp      = op;
        return c;
    endfunction

    function automatic ctrlT branchCtrl(aluOpT op);
        ctrlT c;
        c        = '0;
        c.branch = 1'b1;
        c.aluOp  = op;    // compare sets cond
        return c;
    endfunction

    function automatic ctrlT rTypeCtrl(aluOpT op, logic isShift);
        ctrlT c;
        c          = '0;
        c.regWrite = 1'b1;
        c.regDst   = RegDstRd;
        c.shiftImm = isShift;    // shamt into operand a
        c.aluOp    = op;
        return c;
    endfunction

    always_comb begin
        ctrl = '0;    // unknown codes stay a no-op
        case (opcode)
            OpRType: begin
                case (funct)
                    FnSll:   ctrl = rTypeCtrl(AluSll, 1'b1);
                    FnSrl:   ctrl = rTypeCtrl(AluSrl, 1'b1);
                    FnAdd:   ctrl = rTypeCtrl(AluAdd, 1'b0);
                    FnSub:   ctrl = rTypeCtrl(AluSub, 1'b0);
                    FnMul:   ctrl = rTypeCtrl(AluMul, 1'b0);
                    FnAnd:   ctrl = rTypeCtrl(AluAnd, 1'b0);
                    FnOr:    ctrl = rTypeCtrl(AluOr, 1'b0);
                    FnXor:   ctrl = rTypeCtrl(AluXor, 1'b0);
                    FnNor:   ctrl = rTypeCtrl(AluNor, 1'b0);
                    FnSlt:   ctrl = rTypeCtrl(AluSlt, 1'b0);
                    default: ctrl = '0;
                endcase
            end
            OpLw:   ctrl = loadCtrl(MemWord);
            OpLh:   ctrl = loadCtrl(MemHalf);
            OpLb:   ctrl = loadCtrl(MemByte);
            OpSw:   ctrl = storeCtrl(MemWord);
            OpSh:   ctrl = storeCtrl(MemHalf);
            OpSb:   ctrl = storeCtrl(MemByte);
            OpAddi: ctrl = immCtrl(AluAdd, 1'b0);
            OpSlti: ctrl = immCtrl(AluSlt, 1'b0);
            OpAndi: ctrl = immCtrl(AluAnd, 1'b1);    // logical immediates zero-extend
            OpOri:  ctrl = immCtrl(AluOr, 1'b1);
            OpXori: ctrl = immCtrl(AluXor, 1'b1);
            OpBeq:  ctrl = branchCtrl(AluEq);
            OpBne:  ctrl = branchCtrl(AluNe);
            OpBgtz: ctrl = branchCtrl(AluGtz);
            OpBlez: ctrl = branchCtrl(AluLez);
            OpRegImm: begin
                if (rt == RtBgez) begin
                    ctrl = branchCtrl(AluGez);
                end else if (rt == RtBltz) begin
                    ctrl = branchCtrl(AluLtz);
                end
            end
            OpJ: ctrl.jump = 1'b1;
            OpJal: begin
                ctrl.jump     = 1'b1;
                ctrl.link     = 1'b1;    // r31 gets pc+4
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = RegDstRa;
            end
            OpJr:    ctrl.jumpReg = 1'b1;
            default: ctrl = '0;
        endcase
    end

endmodule

// File: hw/alu.sv
module alu (
    input  mipsPkg::aluOpT op,
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    output mipsPkg::wordT  result,
    output logic           cond
);
    import mipsPkg::*;

    logic aNeg;
    logic aZero;

    assign aNeg  = a[31];
    assign aZero = (a == '0);

    always_comb begin
        result = '0;
        cond   = 1'b0;
        case (op)
            AluAdd: result = a + b;
            AluSub: result = a - b;
            AluMul: result = a * b;            // low word only
            AluSll: result = b << a[4:0];      // a holds shamt
            AluSrl: result = b >> a[4:0];
            AluAnd: result = a & b;
            AluOr:  result = a | b;
            AluXor: result = a ^ b;
            AluNor: result = ~(a | b);
            AluSlt: result = {31'b0, $signed(a) < $signed(b)};

            // branch compares, result unused
            AluEq:  cond = (a == b);
            AluNe:  cond = (a != b);
            AluGez: cond = !aNeg;
            AluLtz: cond = aNeg;
            AluGtz: cond = !aNeg && !aZero;
            AluLez: cond = aNeg || aZero;
            default: begin
                result = '0;
                cond   = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/regFile.sv
module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            we,
    input  mipsPkg::regIdxT waddr,
    input  mipsPkg::wordT   wdata,
    input  mipsPkg::regIdxT raddrA,
    input  mipsPkg::regIdxT raddrB,
    output mipsPkg::wordT   rdataA,
    output mipsPkg::wordT   rdataB
);
    import mipsPkg::*;

    wordT regs [NumRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin    // r0 never written
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, no bypass needed in a single cycle core
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

endmodule

// File: hw/dataMem.sv
module dataMem (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::addrT    addr,
    input  mipsPkg::wordT    wdata,
    input  mipsPkg::memSizeT readSize,
    input  mipsPkg::memSizeT writeSize,
    input  logic             en,
    output mipsPkg::wordT    rdata
);
    import mipsPkg::*;

    logic [7:0] mem [MemWords * 4];

    logic [MemAddrBits-1:0] b0, b1, b2, b3;

    // byte lanes of the addressed word, low lanes follow addr for half/byte
    assign b0 = addr[MemAddrBits-1:0];
    assign b1 = {addr[MemAddrBits-1:1], 1'b1};
    assign b2 = {addr[MemAddrBits-1:2], 2'b10};
    assign b3 = {addr[MemAddrBits-1:2], 2'b11};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < MemWords * 4; i++) begin
                mem[i] <= '0;
            end
        end else if (en) begin
            case (writeSize)
                MemWord: begin
                    mem[b0] <= wdata[7:0];
                    mem[b1] <= wdata[15:8];
                    mem[b2] <= wdata[23:16];
                    mem[b3] <= wdata[31:24];
                end
                MemHalf: begin
                    mem[b0] <= wdata[7:0];
                    mem[b1] <= wdata[15:8];
                end
                MemByte: mem[b0] <= wdata[7:0];
                default: ;    // no store
            endcase
        end
    end

    always_comb begin
        case (readSize)
            MemWord: rdata = {mem[b3], mem[b2], mem[b1], mem[b0]};
            MemHalf: rdata = {{16{mem[b1][7]}}, mem[b1], mem[b0]};
            MemByte: rdata = {{24{mem[b0][7]}}, mem[b0]};
            default: rdata = '0;
        endcase
    end

    function automatic logic misaligned(memSizeT size, addrT a);
        return (size == MemWord && a[1:0] != 2'b00) || (size == MemHalf && a[0]);
    endfunction

    aAligned: assert property (@(posedge clk) disable iff (!rstN)
        en |-> !misaligned(readSize, addr) && !misaligned(writeSize, addr))
        else $error("dataMem: misaligned access at %h", addr);

endmodule

// File: hw/pcUnit.sv
module pcUnit (
    input  logic          clk,
    input  logic          rstN,
    input  logic          en,
    input  mipsPkg::ctrlT ctrl,
    input  logic          cond,
    input  mipsPkg::wordT rsValue,
    input  logic [15:0]   imm,
    input  logic [25:0]   target,
    output mipsPkg::addrT pc,
    output mipsPkg::addrT nextPc
);
    import mipsPkg::*;

    addrT pcPlus4;
    addrT branchTarget;
    addrT jumpTarget;

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], target, 2'b00};    // stays in current 256MB region

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsValue;
        end else if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && cond) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= ResetPc;
        end else if (en) begin
            pc <= nextPc;    // holds on stall
        end
    end

endmodule

// File: hw/mipsCore.sv
module mipsCore (
    input  logic            clk,
    input  logic            rstN,
    input  logic            instrValid,
    input  mipsPkg::wordT   instr,
    output mipsPkg::retireT retire
);
    import mipsPkg::*;

    ctrlT   ctrl;
    regIdxT rsIdx, rtIdx, rdIdx, waddr;
    wordT   rsValue, rtValue, immExt, aluA, aluB, aluResult, memData, wbData;
    addrT   pc, nextPc, linkPc;
    logic   cond;
    logic   regWe;

    assign rsIdx = instr[25:21];
    assign rtIdx = instr[20:16];
    assign rdIdx = instr[15:11];

    mainDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    ////////////////////////////////////////////////////////////
    // operand select
    ////////////////////////////////////////////////////////////
    assign immExt = ctrl.immZeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign aluA   = ctrl.shiftImm ? {27'b0, instr[10:6]} : rsValue;    // shamt for sll/srl
    assign aluB   = ctrl.aluSrcImm ? immExt : rtValue;

    alu uAlu (
        .op     (ctrl.aluOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult),
        .cond   (cond)
    );

    dataMem uDataMem (
        .clk       (clk),
        .rstN      (rstN),
        .addr      (aluResult),
        .wdata     (rtValue),
        .readSize  (ctrl.memRead),
        .writeSize (ctrl.memWrite),
        .en        (instrValid),
        .rdata     (memData)
    );

    ////////////////////////////////////////////////////////////
    // writeback
    ////////////////////////////////////////////////////////////
    assign linkPc = pc + 32'd4;
    assign regWe  = instrValid && ctrl.regWrite;

    always_comb begin
        case (ctrl.regDst)
            RegDstRd: waddr = rdIdx;
            RegDstRa: waddr = RaIdx;
            default:  waddr = rtIdx;
        endcase
    end

    always_comb begin
        if (ctrl.link) begin
            wbData = linkPc;
        end else if (ctrl.memToReg) begin
            wbData = memData;
        end else begin
            wbData = aluResult;
        end
    end

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWe),
        .waddr  (waddr),
        .wdata  (wbData),
        .raddrA (rsIdx),
        .raddrB (rtIdx),
        .rdataA (rsValue),
        .rdataB (rtValue)
    );

    pcUnit uPcUnit (
        .clk     (clk),
        .rstN    (rstN),
        .en      (instrValid),
        .ctrl    (ctrl),
        .cond    (cond),
        .rsValue (rsValue),
        .imm     (instr[15:0]),
        .target  (instr[25:0]),
        .pc      (pc),
        .nextPc  (nextPc)
    );

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retire <= '0;
        end else begin
            retire.valid  <= instrValid;
            retire.regWe  <= regWe && waddr != '0;    // r0 writes are dropped
            retire.rd     <= waddr;
            retire.data   <= wbData;
            retire.pc     <= pc;
            retire.nextPc <= nextPc;
        end
    end

    // data accesses stay inside the data memory
    aMemRange: assert property (@(posedge clk) disable iff (!rstN)
        instrValid && (ctrl.memRead != MemNone || ctrl.memWrite != MemNone)
            |-> aluResult < addrT'(MemWords * 4))
        else $error("mipsCore: data access outside memory at %h", aluResult);

endmodule

// File: tests/tbMipsCore.sv
module tbMipsCore;
    timeunit 1ns;
    timeprecision 1ps;

    import mipsPkg::*;

    typedef logic [MemAddrBits-1:0] byteIdxT;

    localparam int NumInstrs   = 2000;
    localparam int ResetCycles = 5;
    localparam int CycleLimit  = NumInstrs + NumInstrs / 4;    // stalls run near one in eight

    localparam functT RFuncts [10] = '{FnSll, FnSrl, FnAdd, FnSub, FnMul,
                                       FnAnd, FnOr, FnXor, FnNor, FnSlt};
    localparam opcodeT ImmOps [5]   = '{OpAddi, OpAndi, OpOri, OpXori, OpSlti};
    localparam opcodeT LoadOps [3]  = '{OpLw, OpLh, OpLb};
    localparam opcodeT StoreOps [3] = '{OpSw, OpSh, OpSb};
    localparam opcodeT BrOps [4]    = '{OpBeq, OpBne, OpBgtz, OpBlez};
    localparam opcodeT BadOps [4]   = '{6'b010000, 6'b011111, 6'b110000, 6'b111111};

    logic   clk;
    logic   rstN;
    logic   instrValid;
    wordT   instr;
    retireT retire;

    logic [31:0] lfsr = 32'd36;
    wordT        refRegs [NumRegs];
    logic [7:0]  refMem [MemWords * 4];
    addrT        refPc;
    int          cycleCount;

    mipsCore DUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .retire     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // random source
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] randBits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // taps 32,22,2,1
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic wordT genInstr();
        logic [3:0]  kind;
        logic [3:0]  fnSel;
        logic [2:0]  sel3;
        logic [1:0]  sel2;
        regIdxT      rs;
        regIdxT      rt;
        regIdxT      rd;
        byteIdxT     off;
        logic [15:0] imm;
        wordT        w;
        kind = 4'(randBits(4));
        rs   = 5'(randBits(5));
        rt   = 5'(randBits(5));
        rd   = 5'(randBits(5));
        imm  = 16'(randBits(16));
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3: begin
                fnSel = 4'(randBits(4) % 10);
                w     = {OpRType, rs, rt, rd, 5'(randBits(5)), RFuncts[fnSel]};
            end
            4'd4, 4'd5, 4'd6: begin
                sel3 = 3'(randBits(3) % 5);
                w    = {ImmOps[sel3], rs, rt, imm};
            end
            4'd7, 4'd8, 4'd9, 4'd10: begin    // base is r0, offset aligned
                sel2 = 2'(randBits(2) % 3);
                off  = byteIdxT'(randBits(MemAddrBits));
                if (sel2 == 2'd0) begin
                    off[1:0] = 2'b00;
                end else if (sel2 == 2'd1) begin
                    off[0] = 1'b0;
                end
                if (kind[0]) begin
                    w = {StoreOps[sel2], 5'd0, rt, 16'(off)};
                end else begin
                    w = {LoadOps[sel2], 5'd0, rt, 16'(off)};
                end
            end
            4'd11, 4'd12: begin
                sel3 = 3'(randBits(3) % 6);
                if (sel3 < 3'd4) begin
                    w = {BrOps[sel3[1:0]], rs, rt, imm};
                end else begin
                    w = {OpRegImm, rs, (sel3[0] ? RtBltz : RtBgez), imm};
                end
            end
            4'd13: begin
                sel2 = 2'(randBits(2) % 3);
                if (sel2 == 2'd0) begin
                    w = {OpJ, 26'(randBits(26))};
                end else if (sel2 == 2'd1) begin
                    w = {OpJal, 26'(randBits(26))};
                end else begin
                    w = {OpJr, rs, 21'd0};
                end
            end
            4'd14: w = {BadOps[2'(randBits(2))], 26'(randBits(26))};
            default: begin
                if (randBits(1) == 0) begin
                    w = {OpAddi, rs, 5'd0, imm};    // write aimed at r0
                end else begin
                    w = {OpRType, rs, rt, rd, 5'd0, 6'b001000};    // funct not decoded
                end
            end
        endcase
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // ISA reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [7:0] loadByte(byteIdxT base, int k);
        return refMem[base + byteIdxT'(k)];
    endfunction

    task automatic storeByte(input byteIdxT base, input int k, input logic [7:0] v);
        refMem[base + byteIdxT'(k)] = v;
    endtask

    task automatic execModel(input wordT ins, output retireT exp);
        opcodeT     op;
        functT      fn;
        regIdxT     rt;
        regIdxT     dst;
        wordT       a;
        wordT       b;
        wordT       sImm;
        wordT       zImm;
        wordT       val;
        addrT       pcPlus4;
        addrT       next;
        byteIdxT    m;
        logic [7:0] hi;
        logic       we;
        logic       taken;
        op      = ins[31:26];
        fn      = ins[5:0];
        rt      = ins[20:16];
        a       = refRegs[ins[25:21]];
        b       = refRegs[rt];
        sImm    = {{16{ins[15]}}, ins[15:0]};
        zImm    = {16'h0000, ins[15:0]};
        m       = byteIdxT'(a + sImm);
        pcPlus4 = refPc + 4;
        next    = pcPlus4;
        dst     = rt;
        val     = '0;
        we      = 1'b0;
        taken   = 1'b0;
        case (op)
            OpRType: begin
                dst = ins[15:11];
                we  = 1'b1;
                case (fn)
                    FnSll:   val = b << ins[10:6];
                    FnSrl:   val = b >> ins[10:6];
                    FnAdd:   val = a + b;
                    FnSub:   val = a - b;
                    FnMul:   val = a * b;    // low word
                    FnAnd:   val = a & b;
                    FnOr:    val = a | b;
                    FnXor:   val = a ^ b;
                    FnNor:   val = ~(a | b);
                    FnSlt:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: we = 1'b0;
                endcase
            end
            OpAddi: begin
                we  = 1'b1;
                val = a + sImm;
            end
            OpSlti: begin
                we  = 1'b1;
                val = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            end
            OpAndi: begin
                we  = 1'b1;
                val = a & zImm;
            end
            OpOri: begin
                we  = 1'b1;
                val = a | zImm;
            end
            OpXori: begin
                we  = 1'b1;
                val = a ^ zImm;
            end
            OpLw: begin
                we  = 1'b1;
                val = {loadByte(m, 3), loadByte(m, 2), loadByte(m, 1), loadByte(m, 0)};
            end
            OpLh: begin
                we  = 1'b1;
                hi  = loadByte(m, 1);
                val = {{16{hi[7]}}, hi, loadByte(m, 0)};
            end
            OpLb: begin
                we  = 1'b1;
                hi  = loadByte(m, 0);
                val = {{24{hi[7]}}, hi};
            end
            OpSw: begin
                storeByte(m, 0, b[7:0]);
                storeByte(m, 1, b[15:8]);
                storeByte(m, 2, b[23:16]);
                storeByte(m, 3, b[31:24]);
            end
            OpSh: begin
                storeByte(m, 0, b[7:0]);
                storeByte(m, 1, b[15:8]);
            end
            OpSb:     storeByte(m, 0, b[7:0]);
            OpBeq:    taken = (a == b);
            OpBne:    taken = (a != b);
            OpBgtz:   taken = ($signed(a) > 0);
            OpBlez:   taken = ($signed(a) <= 0);
            OpRegImm: taken = (rt == RtBgez) ? ($signed(a) >= 0) : ($signed(a) < 0);
            OpJ:      next = {pcPlus4[31:28], ins[25:0], 2'b00};
            OpJal: begin
                next = {pcPlus4[31:28], ins[25:0], 2'b00};
                we   = 1'b1;
                dst  = RaIdx;
                val  = pcPlus4;
            end
            OpJr:    next = a;
            default: ;    // no-op
        endcase
        if (taken) begin
            next = pcPlus4 + {sImm[29:0], 2'b00};
        end
        exp        = '0;
        exp.valid  = 1'b1;
        exp.regWe  = we && dst != '0;
        exp.rd     = dst;
        exp.data   = val;
        exp.pc     = refPc;
        exp.nextPc = next;
        if (exp.regWe) begin
            refRegs[dst] = val;
        end
        refPc = next;
    endtask

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    task automatic reportError(input string msg);
        $display("Error: %0d ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "mismatch against the reference model");
    endtask

    task automatic checkWord(input wordT got, input wordT exp, input string what);
        if (got !== exp) begin
            reportError($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic checkAddr(input addrT got, input addrT exp, input string what);
        if (got !== exp) begin
            reportError($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic checkRetire(input retireT got, input retireT exp, input string what);
        if (got.valid !== exp.valid) begin
            reportError($sformatf("%s: valid is %b, expected %b", what, got.valid, exp.valid));
        end
        if (got.regWe !== exp.regWe) begin
            reportError($sformatf("%s: regWe is %b, expected %b", what, got.regWe, exp.regWe));
        end
        if (exp.regWe && got.rd !== exp.rd) begin
            reportError($sformatf("%s: rd is %0d, expected %0d", what, got.rd, exp.rd));
        end
        if (exp.regWe) begin
            checkWord(got.data, exp.data, $sformatf("%s: data", what));
        end
        checkAddr(got.pc, exp.pc, $sformatf("%s: pc", what));    // stalls keep pc too
        if (exp.valid) begin
            checkAddr(got.nextPc, exp.nextPc, $sformatf("%s: nextPc", what));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // run control
    ////////////////////////////////////////////////////////////
    initial begin
        retireT pending;
        retireT next;
        wordT   ins;
        string  pendingTag;
        string  tag;
        int     issued;
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= '0;
        refRegs = '{default: '0};
        refMem  = '{default: '0};
        refPc   = ResetPc;
        issued  = 0;
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        pending    = '0;
        pending.pc = ResetPc;
        pendingTag = "reset";
        checkRetire(retire, pending, "after reset");

        // retire of the word driven one edge earlier is checked each negedge
        while (issued < NumInstrs) begin
            @(posedge clk);
            if (randBits(3) == 0) begin
                instrValid <= 1'b0;
                instr      <= randBits(32);    // ignored by the DUT
                next        = '0;
                next.pc     = refPc;
                tag         = "stall";
            end else begin
                ins         = genInstr();
                instrValid <= 1'b1;
                instr      <= ins;
                execModel(ins, next);
                issued++;
                tag = $sformatf("instr %0d (%h)", issued, ins);
            end
            @(negedge clk);
            checkRetire(retire, pending, pendingTag);
            pending    = next;
            pendingTag = tag;
        end
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        checkRetire(retire, pending, pendingTag);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not complete within %0d cycles", CycleLimit);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

// File: files.f
hw/mipsPkg.sv
hw/mainDecoder.sv
hw/alu.sv
hw/regFile.sv
hw/dataMem.sv
hw/pcUnit.sv
hw/mipsCore.sv
tests/tbMipsCore.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tbMipsCore \
    -f files.f -o simMipsCore

./obj_dir/simMipsCore | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
